//--- vlog.f
common/ledmat_pkg.sv
control/uart_rx.sv
control/cmd_control.sv
verilog/frame_buffer.sv
scan/frame_fetch.sv
scan/matrix_scan.sv
verilog/led_matrix_top.sv
dv/led_matrix_properties.sv
dv/tb_led_matrix.sv

//--- Bender.yml
package:
  name: led_matrix

sources:
  - common/ledmat_pkg.sv
  - control/uart_rx.sv
  - control/cmd_control.sv
  - verilog/frame_buffer.sv
  - scan/frame_fetch.sv
  - scan/matrix_scan.sv
  - verilog/led_matrix_top.sv
  - target: dv
    files:
      - dv/led_matrix_properties.sv
      - dv/tb_led_matrix.sv

//--- dv/tb_led_matrix.sv
`timescale 1ns/10ps

module tb_led_matrix;
    import ledmat_pkg::*;

    localparam int W           = 8;
    localparam int H           = 8;
    localparam int TPB         = 8;
    localparam int OE_UNIT     = 2;
    localparam int RW          = $clog2(H / 2);
    localparam int LATCH_LIMIT = 400;  // longest plane is about 100 cycles
    localparam int OE_LIMIT    = 300;

    logic          clk_in;
    logic          rst;
    logic          rx;
    rgb_bits_t     rgb1;
    rgb_bits_t     rgb2;
    logic          clk_pixel;
    logic          row_latch;
    logic          oe_n;
    logic [RW-1:0] row_addr;

    // model of what the panel should show
    rgb565_t       model_px [W*H];
    rgb_bits_t     model_rgb;
    bright_mask_t  model_bright;

    rgb_bits_t     cap1 [W];   // columns of the row being shifted
    rgb_bits_t     cap2 [W];
    int            col_idx   = 0;
    int            latch_cnt = 0;
    int            err_cnt     = 0;
    int            timeout_cnt = 0;
    integer        seed        = 32'hf2fc7354;
    logic [31:0]   rnd;

    led_matrix_top #(
        .pixel_width  (W),
        .pixel_height (H),
        .ticks_per_bit(TPB),
        .oe_unit      (OE_UNIT)
    ) i_dut (
        .clk_in   (clk_in),
        .rst      (rst),
        .rx       (rx),
        .rgb1     (rgb1),
        .rgb2     (rgb2),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .oe_n     (oe_n),
        .row_addr (row_addr)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // panel side monitor, stable values at the falling edge
    always @(negedge clk_in) begin
        if (rst) begin
            col_idx   <= 0;
            latch_cnt <= 0;
        end else begin
            if (clk_pixel) begin
                cap1[col_idx] <= rgb1;
                cap2[col_idx] <= rgb2;
                col_idx       <= (col_idx == W - 1) ? 0 : col_idx + 1;
            end
            if (row_latch)
                latch_cnt <= latch_cnt + 1;
        end
    end

    // one plane bit of a pixel, red and blue widened with their msb at plane 0
    function automatic rgb_bits_t expected_bits(input rgb565_t px, input int plane);
        rgb_bits_t b;
        if (plane == 0)
            b = {px.blue[4], px.green[0], px.red[4]};
        else
            b = {px.blue[plane-1], px.green[plane], px.red[plane-1]};
        if (!model_bright[plane])
            b = '0;
        return b & model_rgb;
    endfunction

    task automatic report_and_finish();
        $display("mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 err_cnt, timeout_cnt, i_dut.i_properties.fail_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && i_dut.i_properties.fail_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    task automatic check_rgb(input rgb_bits_t got, input rgb_bits_t exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_row(input logic [RW-1:0] got, input logic [RW-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: row_addr got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_show_len(input int got, input int exp);
        if (got != exp) begin
            err_cnt++;
            $display("[ERROR] %0t: oe_n low for %0d cycles, expected %0d", $time, got, exp);
        end
    endtask

    // 8N1 frame plus one idle bit
    task automatic send_byte(input logic [7:0] data, input bit bad_stop);
        logic [10:0] bits;
        bits = {1'b1, ~bad_stop, data, 1'b0};
        @(posedge clk_in);
        for (int i = 0; i < 11; i++) begin
            rx <= bits[i];
            repeat (TPB) @(posedge clk_in);
        end
    endtask

    task automatic load_frame();
        rgb565_t px;
        send_byte(OP_LOAD_FRAME, 1'b0);
        for (int i = 0; i < W * H; i++) begin
            rnd         = $random(seed);
            px          = rnd[15:0];
            model_px[i] = px;
            send_byte(px[15:8], 1'b0);  // high byte first
            send_byte(px[7:0], 1'b0);
        end
    endtask

    task automatic wait_latch();
        int t;
        t = 0;
        do begin
            @(negedge clk_in);
            t++;
        end while (!row_latch && t < LATCH_LIMIT);
        if (!row_latch) begin
            $display("timeout: no row latch within %0d cycles", LATCH_LIMIT);
            timeout_cnt++;
            report_and_finish();
        end
    endtask

    // checks n latched planes, skipping the row in flight on entry
    task automatic check_scan(input int n);
        int lat;
        int plane;
        int row;
        int len;
        int t;
        wait_latch();
        for (int k = 0; k < n; k++) begin
            wait_latch();
            lat   = latch_cnt;  // latches before this one
            plane = lat % BRIGHT_BITS;
            row   = (lat / BRIGHT_BITS) % (H / 2);
            for (int c = 0; c < W; c++) begin
                check_rgb(cap1[c], expected_bits(model_px[row * W + c], plane),
                          $sformatf("rgb1 row %0d plane %0d col %0d", row, plane, c));
                check_rgb(cap2[c], expected_bits(model_px[(row + H / 2) * W + c], plane),
                          $sformatf("rgb2 row %0d plane %0d col %0d", row + H / 2, plane, c));
            end
            t = 0;
            do begin
                @(negedge clk_in);
                t++;
            end while (oe_n && t < OE_LIMIT);
            if (oe_n) begin
                $display("timeout: oe_n never went low after the row latch");
                timeout_cnt++;
                report_and_finish();
            end
            len = 0;
            while (!oe_n && len < OE_LIMIT) begin
                check_row(row_addr, RW'(row));
                len++;
                @(negedge clk_in);
            end
            if (!oe_n) begin
                $display("timeout: oe_n stuck low for %0d cycles", OE_LIMIT);
                timeout_cnt++;
                report_and_finish();
            end
            check_show_len(len, OE_UNIT << plane);
        end
    endtask

    initial begin
        rst          = 1'b1;
        rx           = 1'b1;
        model_rgb    = '1;
        model_bright = '1;
        repeat (5) @(posedge clk_in);
        rst <= 1'b0;

        load_frame();
        repeat (4 * TPB) @(posedge clk_in);
        check_scan(24);  // every plane of every row pair

        rnd = $random(seed);
        if (rnd[2:0] == 3'b111)
            rnd[0] = 1'b0;  // at least one channel off
        send_byte(OP_SET_RGB, 1'b0);
        send_byte(rnd[7:0], 1'b0);
        model_rgb = rnd[2:0];
        repeat (4 * TPB) @(posedge clk_in);
        check_scan(24);

        send_byte(OP_SET_RGB, 1'b0);
        send_byte(8'h07, 1'b0);
        model_rgb = 3'b111;
        rnd = $random(seed);
        if (rnd[5:0] == 6'h3f)
            rnd[0] = 1'b0;  // at least one plane off
        send_byte(OP_SET_BRIGHT, 1'b0);
        send_byte(rnd[7:0], 1'b0);
        model_bright = rnd[5:0];
        repeat (4 * TPB) @(posedge clk_in);
        check_scan(24);

        // 'Q' is no opcode, the R frame is broken
        send_byte(8'h51, 1'b0);
        send_byte(OP_SET_RGB, 1'b1);
        rnd = $random(seed);
        if (rnd[5:0] == model_bright || rnd[5:0] == 6'h00)
            rnd[5:0] = ~model_bright;  // new mask, never blank
        send_byte(OP_SET_BRIGHT, 1'b0);
        send_byte(rnd[7:0], 1'b0);
        model_bright = rnd[5:0];
        repeat (4 * TPB) @(posedge clk_in);
        check_scan(24);

        report_and_finish();
    end

endmodule

//--- dv/led_matrix_properties.sv
`timescale 1ns/10ps

module led_matrix_properties (
    input logic clk_in,
    input logic rst,
    input logic clk_pixel,
    input logic row_latch,
    input logic oe_n
);

    int fail_cnt = 0;  // failed assertions so far

    // panel dark and idle right out of reset
    quiet_after_reset: assert property (
        @(posedge clk_in) rst |=> (oe_n && !row_latch && !clk_pixel)
    ) else begin
        fail_cnt++;
        $error("panel outputs active right after reset");
    end

    latch_one_cycle: assert property (
        @(posedge clk_in) disable iff (rst) row_latch |=> !row_latch
    ) else begin
        fail_cnt++;
        $error("row_latch high for more than one cycle");
    end

    // no light while data moves
    dark_while_busy: assert property (
        @(posedge clk_in) disable iff (rst) !(!oe_n && (clk_pixel || row_latch))
    ) else begin
        fail_cnt++;
        $error("oe_n low during clk_pixel or row_latch");
    end

endmodule

bind led_matrix_top led_matrix_properties i_properties (
    .clk_in   (clk_in),
    .rst      (rst),
    .clk_pixel(clk_pixel),
    .row_latch(row_latch),
    .oe_n     (oe_n)
);

//--- verilog/led_matrix_top.sv
`timescale 1ns/10ps

module led_matrix_top #(
    parameter int pixel_width   = 64,
    parameter int pixel_height  = 32,
    parameter int ticks_per_bit = 9,
    parameter int oe_unit       = 8
) (
    input  logic                              clk_in,
    input  logic                              rst,
    input  logic                              rx,
    output ledmat_pkg::rgb_bits_t             rgb1,
    output ledmat_pkg::rgb_bits_t             rgb2,
    output logic                              clk_pixel,
    output logic                              row_latch,
    output logic                              oe_n,
    output logic [$clog2(pixel_height/2)-1:0] row_addr
);
    import ledmat_pkg::*;

    localparam int BAW = $clog2(pixel_width * pixel_height * 2);  // byte address
    localparam int WAW = $clog2(pixel_width * pixel_height);      // word address
    localparam int CW  = $clog2(pixel_width);
    localparam int RW  = $clog2(pixel_height / 2);

    logic [7:0]     rx_data;
    logic           rx_valid;
    rgb_bits_t      rgb_enable;
    bright_mask_t   brightness_enable;
    logic           wr_en;
    logic [BAW-1:0] wr_addr;
    logic [7:0]     wr_data;
    logic           rd_en;
    logic [WAW-1:0] rd_addr;
    rgb565_t        rd_data;
    logic           pixel_load_start;
    logic [CW-1:0]  column_address;
    logic [RW-1:0]  row_address;       // row being shifted
    bright_mask_t   brightness_mask;

    uart_rx #(
        .ticks_per_bit(ticks_per_bit)
    ) i_uart_rx (
        .clk_in  (clk_in),
        .rst     (rst),
        .rx      (rx),
        .rx_data (rx_data),
        .rx_valid(rx_valid)
    );

    cmd_control #(
        .pixel_width (pixel_width),
        .pixel_height(pixel_height)
    ) i_cmd_control (
        .clk_in           (clk_in),
        .rst              (rst),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data)
    );

    // port a from the controller, port b to the fetch
    frame_buffer #(
        .pixel_width (pixel_width),
        .pixel_height(pixel_height)
    ) i_frame_buffer (
        .clk_in (clk_in),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    frame_fetch #(
        .pixel_width (pixel_width),
        .pixel_height(pixel_height)
    ) i_frame_fetch (
        .clk_in           (clk_in),
        .rst              (rst),
        .pixel_load_start (pixel_load_start),
        .column_address   (column_address),
        .row_address      (row_address),
        .brightness_mask  (brightness_mask),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_data          (rd_data),
        .rgb1             (rgb1),
        .rgb2             (rgb2)
    );

    matrix_scan #(
        .pixel_width (pixel_width),
        .pixel_height(pixel_height),
        .oe_unit     (oe_unit)
    ) i_matrix_scan (
        .clk_in          (clk_in),
        .rst             (rst),
        .pixel_load_start(pixel_load_start),
        .column_address  (column_address),
        .row_address     (row_address),
        .brightness_mask (brightness_mask),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .oe_n            (oe_n),
        .row_addr        (row_addr)
    );

endmodule

//--- scan/matrix_scan.sv
`timescale 1ns/10ps

module matrix_scan #(
    parameter int pixel_width  = 64,
    parameter int pixel_height = 32,
    parameter int oe_unit      = 8
) (
    input  logic                              clk_in,
    input  logic                              rst,
    output logic                              pixel_load_start,
    output logic [$clog2(pixel_width)-1:0]    column_address,
    output logic [$clog2(pixel_height/2)-1:0] row_address,
    output ledmat_pkg::bright_mask_t          brightness_mask,
    output logic                              clk_pixel,
    output logic                              row_latch,
    output logic                              oe_n,
    output logic [$clog2(pixel_height/2)-1:0] row_addr
);
    import ledmat_pkg::*;

    localparam int CW = $clog2(pixel_width);
    localparam int RW = $clog2(pixel_height / 2);
    localparam int PW = $clog2(COL_PERIOD);
    localparam int BW = $clog2(BRIGHT_BITS);
    localparam int SW = $clog2(oe_unit << (BRIGHT_BITS - 1));  // longest show time

    scan_state_e   state;
    logic [PW-1:0] phase;
    logic [BW-1:0] plane;
    logic [SW-1:0] show_cnt;  // counts down to 0

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state          <= SCAN_SHIFT;
            phase          <= '0;
            column_address <= '0;
            row_address    <= '0;
            row_addr       <= '0;
            plane          <= '0;
            show_cnt       <= '0;
        end else begin
            case (state)
                SCAN_SHIFT: begin
                    if (phase == PW'(COL_PERIOD - 1)) begin
                        phase <= '0;
                        if (column_address == CW'(pixel_width - 1)) begin
                            column_address <= '0;
                            row_addr       <= row_address;  // new row on the latch cycle
                            state          <= SCAN_LATCH;
                        end else begin
                            column_address <= column_address + 1'b1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                SCAN_LATCH: begin
                    show_cnt <= SW'((oe_unit << plane) - 1);  // binary weighted
                    state    <= SCAN_SHOW;
                end
                SCAN_SHOW: begin
                    if (show_cnt == '0) begin
                        state <= SCAN_SHIFT;
                        if (plane == BW'(BRIGHT_BITS - 1)) begin
                            plane <= '0;
                            if (row_address == RW'(pixel_height / 2 - 1))
                                row_address <= '0;
                            else
                                row_address <= row_address + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        show_cnt <= show_cnt - 1'b1;
                    end
                end
                default: state <= SCAN_SHIFT;
            endcase
        end
    end

    assign pixel_load_start = (state == SCAN_SHIFT) && (phase == '0);
    assign clk_pixel        = (state == SCAN_SHIFT) && (phase == PW'(COL_PERIOD - 1));
    assign row_latch        = (state == SCAN_LATCH);
    assign oe_n             = (state != SCAN_SHOW);   // active low, lit only while showing
    assign brightness_mask  = bright_mask_t'(1) << plane;

endmodule

//--- scan/frame_fetch.sv
`timescale 1ns/10ps

module frame_fetch #(
    parameter int pixel_width  = 64,
    parameter int pixel_height = 32
) (
    input  logic                                        clk_in,
    input  logic                                        rst,
    input  logic                                        pixel_load_start,
    input  logic [$clog2(pixel_width)-1:0]              column_address,
    input  logic [$clog2(pixel_height/2)-1:0]           row_address,
    input  ledmat_pkg::bright_mask_t                    brightness_mask,
    input  ledmat_pkg::rgb_bits_t                       rgb_enable,
    input  ledmat_pkg::bright_mask_t                    brightness_enable,
    output logic                                        rd_en,
    output logic [$clog2(pixel_width*pixel_height)-1:0] rd_addr,
    input  ledmat_pkg::rgb565_t                         rd_data,
    output ledmat_pkg::rgb_bits_t                       rgb1,
    output ledmat_pkg::rgb_bits_t                       rgb2
);
    import ledmat_pkg::*;

    localparam int AW = $clog2(pixel_width * pixel_height);

    logic [COL_PERIOD-2:1] load_pipe;  // bit 1 top data back, last bit bottom data back
    logic [AW-1:0]         top_index;
    logic [AW-1:0]         bottom_index;
    rgb565_t               top_word;
    rgb565_t               bottom_word;
    bright_mask_t          plane_sel;

    // pick one plane bit out of a pixel
    function automatic rgb_bits_t plane_bits(input rgb565_t px, input bright_mask_t sel,
                                             input rgb_bits_t en);
        logic [5:0] red6;
        logic [5:0] green6;
        logic [5:0] blue6;
        red6   = {px.red, px.red[4]};    // 5 to 6 bits, msb repeated
        green6 = px.green;
        blue6  = {px.blue, px.blue[4]};
        return {en[2] & |(blue6 & sel), en[1] & |(green6 & sel), en[0] & |(red6 & sel)};
    endfunction

    assign top_index    = AW'(row_address) * AW'(pixel_width) + AW'(column_address);
    assign bottom_index = top_index + AW'(pixel_width * pixel_height / 2);  // row r + H/2

    // phase 0 top word, phase 1 bottom word
    assign rd_en   = pixel_load_start | load_pipe[1];
    assign rd_addr = pixel_load_start ? top_index : bottom_index;

    always_ff @(posedge clk_in) begin
        if (rst)
            load_pipe <= '0;
        else
            load_pipe <= {load_pipe[COL_PERIOD-3:1], pixel_load_start};
    end

    always_ff @(posedge clk_in) begin
        if (load_pipe[1])
            top_word <= rd_data;
        if (load_pipe[COL_PERIOD-2])
            bottom_word <= rd_data;
    end

    assign plane_sel = brightness_mask & brightness_enable;
    assign rgb1      = plane_bits(top_word, plane_sel, rgb_enable);
    assign rgb2      = plane_bits(bottom_word, plane_sel, rgb_enable);

endmodule

//--- verilog/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer #(
    parameter int pixel_width  = 64,
    parameter int pixel_height = 32
) (
    input  logic                                          clk_in,
    input  logic                                          wr_en,
    input  logic [$clog2(pixel_width*pixel_height*2)-1:0] wr_addr,
    input  logic [7:0]                                    wr_data,
    input  logic                                          rd_en,
    input  logic [$clog2(pixel_width*pixel_height)-1:0]   rd_addr,
    output ledmat_pkg::rgb565_t                           rd_data
);
    localparam int DEPTH = pixel_width * pixel_height;
    localparam int AW    = $clog2(DEPTH * 2);

    logic [7:0] bank_hi [DEPTH];  // even byte addresses
    logic [7:0] bank_lo [DEPTH];  // odd byte addresses

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0])
                bank_lo[wr_addr[AW-1:1]] <= wr_data;
            else
                bank_hi[wr_addr[AW-1:1]] <= wr_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_en)
            rd_data <= {bank_hi[rd_addr], bank_lo[rd_addr]};
    end

endmodule

//--- control/cmd_control.sv
`timescale 1ns/10ps

module cmd_control #(
    parameter int pixel_width  = 64,
    parameter int pixel_height = 32
) (
    input  logic                                          clk_in,
    input  logic                                          rst,
    input  logic [7:0]                                    rx_data,
    input  logic                                          rx_valid,
    output ledmat_pkg::rgb_bits_t                         rgb_enable,
    output ledmat_pkg::bright_mask_t                      brightness_enable,
    output logic                                          wr_en,
    output logic [$clog2(pixel_width*pixel_height*2)-1:0] wr_addr,
    output logic [7:0]                                    wr_data
);
    import ledmat_pkg::*;

    localparam int FRAME_BYTES = pixel_width * pixel_height * 2;
    localparam int AW          = $clog2(FRAME_BYTES);

    ctrl_state_e   state;
    cmd_opcode_e   arg_op;    // opcode waiting for its argument
    logic [AW-1:0] byte_cnt;  // next byte address of a frame load

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state             <= CTRL_IDLE;
            arg_op            <= OP_SET_RGB;
            byte_cnt          <= '0;
            wr_en             <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    CTRL_IDLE: begin
                        case (rx_data)
                            OP_SET_RGB, OP_SET_BRIGHT: begin
                                arg_op <= cmd_opcode_e'(rx_data);
                                state  <= CTRL_ARG;
                            end
                            OP_LOAD_FRAME: begin
                                byte_cnt <= '0;
                                state    <= CTRL_LOAD;
                            end
                            default: state <= CTRL_IDLE;  // unknown opcode
                        endcase
                    end
                    CTRL_ARG: begin
                        if (arg_op == OP_SET_RGB)
                            rgb_enable <= rx_data[2:0];
                        else
                            brightness_enable <= rx_data[BRIGHT_BITS-1:0];
                        state <= CTRL_IDLE;
                    end
                    CTRL_LOAD: begin
                        wr_en    <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == AW'(FRAME_BYTES - 1))
                            state <= CTRL_IDLE;  // last byte of the frame
                    end
                    default: state <= CTRL_IDLE;
                endcase
            end
        end
    end

    // write port payload
    always_ff @(posedge clk_in) begin
        if (rx_valid && state == CTRL_LOAD) begin
            wr_addr <= byte_cnt;
            wr_data <= rx_data;
        end
    end

endmodule

//--- control/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int ticks_per_bit = 9
) (
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int TW = $clog2(ticks_per_bit + 1);

    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;     // for falling edge of start bit
    logic          busy;
    logic [TW-1:0] tick_cnt;
    logic [3:0]    bit_cnt;     // 0 start, 1..8 data, 9 stop
    logic [7:0]    shift_reg;
    logic          sample;

    assign sample = busy && (tick_cnt == TW'(ticks_per_bit - 1));

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk_in) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync) begin
                    busy     <= 1'b1;
                    tick_cnt <= TW'(ticks_per_bit / 2);  // half bit, lands mid-period
                    bit_cnt  <= '0;
                end
            end else if (sample) begin
                tick_cnt <= '0;
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0 && rx_sync) begin
                    busy <= 1'b0;  // glitch, not a real start bit
                end else if (bit_cnt == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_sync;  // low stop bit drops the byte
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
            shift_reg <= {rx_sync, shift_reg[7:1]};  // lsb first
        if (sample && bit_cnt == 4'd9 && rx_sync)
            rx_data <= shift_reg;
    end

endmodule

//--- common/ledmat_pkg.sv
package ledmat_pkg;

    // brightness planes per colour, plane 0 is the shortest
    localparam int BRIGHT_BITS = 6;

    // clocks per shifted column
    localparam int COL_PERIOD = 4;

    // one-hot plane select
    typedef logic [BRIGHT_BITS-1:0] bright_mask_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_bits_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // serial command bytes
    typedef enum logic [7:0] {
        OP_SET_BRIGHT = 8'h42,  // 'B'
        OP_LOAD_FRAME = 8'h4c,  // 'L'
        OP_SET_RGB    = 8'h52   // 'R'
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_ARG  = 2'd1,
        CTRL_LOAD = 2'd2
    } ctrl_state_e;

    typedef enum logic [1:0] {
        SCAN_SHIFT = 2'd0,
        SCAN_LATCH = 2'd1,
        SCAN_SHOW  = 2'd2
    } scan_state_e;

endpackage
